// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mips_cpu_bus
FILELIST  = mips_cpu_bus.f
OBJDIR    = obj_dir
PASS_MSG  = >>> PASS

.PHONY: sim clean

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)

// ==== mips_cpu_bus.f ====
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/cpu_control.sv
rtl/mips_cpu_bus.sv
verif/mips_cpu_bus_chk.sv
verif/tb_mips_cpu_bus.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ns

module alu import isa_pkg::*; (
    input  word_t    instr,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output word_t    result,
    output reg_idx_t dest,
    output logic     writes_reg,
    output word_t    mem_addr
);

    opcode_t op;
    funct_t  fn;
    word_t   imm_sext;
    word_t   imm_zext;
    logic [4:0] shamt;

    assign op       = opcode_t'(instr[31:26]);
    assign fn       = funct_t'(instr[5:0]);
    assign shamt    = instr[10:6];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'b0, instr[15:0]};

    // base plus signed offset, used by LW and SW
    assign mem_addr = rs_data + imm_sext;

    always_comb begin
        result     = '0;
        dest       = instr[20:16];
        writes_reg = 1'b0;
        case (op)
            SPECIAL: begin
                dest       = instr[15:11];
                writes_reg = 1'b1;
                case (fn)
                    SLL:  result = rt_data << shamt;
                    SRL:  result = rt_data >> shamt;
                    SRA:  result = $signed(rt_data) >>> shamt;
                    ADDU: result = rs_data + rt_data;
                    SUBU: result = rs_data - rt_data;
                    AND:  result = rs_data & rt_data;
                    OR:   result = rs_data | rt_data;
                    XOR:  result = rs_data ^ rt_data;
                    SLT:  result = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    SLTU: result = {31'b0, rs_data < rt_data};
                    // JR and unknown functions
                    default: writes_reg = 1'b0;
                endcase
            end
            ADDIU: {writes_reg, result} = {1'b1, rs_data + imm_sext};
            SLTI:  {writes_reg, result} = {1'b1, 31'b0, $signed(rs_data) < $signed(imm_sext)};
            // sign extended, then compared unsigned
            SLTIU: {writes_reg, result} = {1'b1, 31'b0, rs_data < imm_sext};
            ANDI:  {writes_reg, result} = {1'b1, rs_data & imm_zext};
            ORI:   {writes_reg, result} = {1'b1, rs_data | imm_zext};
            XORI:  {writes_reg, result} = {1'b1, rs_data ^ imm_zext};
            LUI:   {writes_reg, result} = {1'b1, instr[15:0], 16'b0};
            // load data is picked up by the control
            LW:    writes_reg = 1'b1;
            default: writes_reg = 1'b0;
        endcase
    end

endmodule

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit import isa_pkg::*, bus_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    input  word_t rs_data,
    input  word_t rt_data,
    input  logic  retire,
    output word_t pc
);

    opcode_t op;
    funct_t  fn;
    word_t   pc_plus4;
    word_t   br_offset;
    logic    pending;
    word_t   target;
    logic    taken;
    word_t   next_target;

    assign op        = opcode_t'(instr[31:26]);
    assign fn        = funct_t'(instr[5:0]);
    assign pc_plus4  = pc + 32'd4;
    assign br_offset = {{14{instr[15]}}, instr[15:0], 2'b00};

    always_comb begin
        taken       = 1'b0;
        next_target = pc_plus4 + br_offset;
        case (op)
            BEQ:     taken = (rs_data == rt_data);
            BNE:     taken = (rs_data != rt_data);
            J:       {taken, next_target} = {1'b1, pc[31:28], instr[25:0], 2'b00};
            SPECIAL: {taken, next_target} = {fn == JR, rs_data};
            default: taken = 1'b0;
        endcase
    end

    // the jump lands one retire later, after the delay slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_VECTOR;
            pending <= 1'b0;
        end else if (retire) begin
            pc      <= pending ? target : pc_plus4;
            pending <= taken;
            target  <= next_target;
        end
    end

endmodule

// ==== rtl/bus_pkg.sv ====
package bus_pkg;

    // one instruction in flight, MEM only for LW and SW
    typedef enum logic [1:0] {
        FETCH  = 2'd0,
        EXEC   = 2'd1,
        MEM    = 2'd2,
        HALTED = 2'd3
    } state_t;

    // boot address after reset
    localparam logic [31:0] RESET_VECTOR = 32'hBFC00000;

    // word accesses only
    localparam logic [3:0] BYTE_EN_ALL = 4'b1111;

endpackage

// ==== rtl/cpu_control.sv ====
`timescale 1ns/1ns

module cpu_control import isa_pkg::*, bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  word_t    readdata,
    input  word_t    pc,
    input  word_t    result,
    input  reg_idx_t dest,
    input  logic     writes_reg,
    input  word_t    mem_addr,
    input  word_t    rt_data,
    output word_t    instr,
    output logic     retire,
    output logic     wr_en,
    output reg_idx_t wr_addr,
    output word_t    wr_data,
    output word_t    address,
    output logic     read,
    output logic     write,
    output word_t    writedata,
    output logic     active
);

    state_t  state;
    state_t  next_state;
    opcode_t op;
    logic    is_load;
    logic    is_store;
    logic    pc_zero;

    assign op       = opcode_t'(instr[31:26]);
    assign is_load  = (op == LW);
    assign is_store = (op == SW);
    assign pc_zero  = (pc == '0);

    always_comb begin
        next_state = state;
        case (state)
            FETCH: begin
                if (pc_zero) begin
                    next_state = HALTED;
                end else if (!waitrequest) begin
                    next_state = EXEC;
                end
            end
            EXEC:    next_state = (is_load || is_store) ? MEM : FETCH;
            MEM:     next_state = waitrequest ? MEM : FETCH;
            default: next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // instruction word captured when the fetch completes
    always_ff @(posedge clk) begin
        if (state == FETCH && !pc_zero && !waitrequest) begin
            instr <= readdata;
        end
    end

    // last cycle of the instruction
    assign retire = (state == EXEC && !is_load && !is_store) ||
                    (state == MEM && !waitrequest);

    assign wr_en   = retire && writes_reg;
    assign wr_addr = dest;
    assign wr_data = is_load ? readdata : result;

    // no fetch is issued at pc zero
    assign read      = (state == FETCH && !pc_zero) || (state == MEM && is_load);
    assign write     = (state == MEM && is_store);
    assign address   = (state == MEM) ? mem_addr : pc;
    assign writedata = rt_data;
    assign active    = (state != HALTED);

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int OP_W      = 6;
    localparam int FUNCT_W   = 6;
    localparam int REG_COUNT = 32;
    localparam int REG_V0    = 2;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // primary opcode, instr[31:26]
    typedef enum logic [OP_W-1:0] {
        SPECIAL = 6'b000000,
        J       = 6'b000010,
        BEQ     = 6'b000100,
        BNE     = 6'b000101,
        ADDIU   = 6'b001001,
        SLTI    = 6'b001010,
        SLTIU   = 6'b001011,
        ANDI    = 6'b001100,
        ORI     = 6'b001101,
        XORI    = 6'b001110,
        LUI     = 6'b001111,
        LW      = 6'b100011,
        SW      = 6'b101011
    } opcode_t;

    // function field of SPECIAL, instr[5:0]
    typedef enum logic [FUNCT_W-1:0] {
        SLL  = 6'b000000,
        SRL  = 6'b000010,
        SRA  = 6'b000011,
        JR   = 6'b001000,
        ADDU = 6'b100001,
        SUBU = 6'b100011,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        SLT  = 6'b101010,
        SLTU = 6'b101011
    } funct_t;

endpackage

// ==== rtl/mips_cpu_bus.sv ====
`timescale 1ns/1ns

module mips_cpu_bus import isa_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    word_t    pc;
    word_t    instr;
    word_t    rs_data;
    word_t    rt_data;
    word_t    result;
    word_t    mem_addr;
    reg_idx_t dest;
    logic     writes_reg;
    logic     retire;
    logic     wr_en;
    reg_idx_t wr_addr;
    word_t    wr_data;

    reg_file reg_file_i (
        .clk(clk), .reset(reset),
        .rs_addr(instr[25:21]), .rt_addr(instr[20:16]),
        .rs_data(rs_data), .rt_data(rt_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .v0(register_v0)
    );

    alu alu_i (
        .instr(instr), .rs_data(rs_data), .rt_data(rt_data),
        .result(result), .dest(dest), .writes_reg(writes_reg), .mem_addr(mem_addr)
    );

    branch_unit branch_unit_i (
        .clk(clk), .reset(reset), .instr(instr), .rs_data(rs_data),
        .rt_data(rt_data), .retire(retire), .pc(pc)
    );

    cpu_control cpu_control_i (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .pc(pc), .result(result), .dest(dest), .writes_reg(writes_reg),
        .mem_addr(mem_addr), .rt_data(rt_data), .instr(instr), .retire(retire),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .address(address),
        .read(read), .write(write), .writedata(writedata), .active(active)
    );

    assign byteenable = BYTE_EN_ALL;

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_addr,
    input  reg_idx_t rt_addr,
    output word_t    rs_data,
    output word_t    rt_data,
    input  logic     wr_en,
    input  reg_idx_t wr_addr,
    input  word_t    wr_data,
    output word_t    v0
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            // $zero never written, stays at its reset value
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[REG_V0];

endmodule

// ==== verif/mips_cpu_bus_chk.sv ====
`timescale 1ns/1ns

module mips_cpu_bus_chk (
    input logic        clk,
    input logic        reset,
    input logic        active,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic [31:0] address
);

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write are high in the same cycle");

    // a stalled transfer keeps its address and strobes
    held_under_wait: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("bus request changed while waitrequest was high");

    active_after_reset: assert property (@(posedge clk) $fell(reset) |-> active)
        else $error("active is low in the first cycle after reset");

endmodule

bind mips_cpu_bus mips_cpu_bus_chk chk_i (
    .clk(clk), .reset(reset), .active(active), .read(read), .write(write),
    .waitrequest(waitrequest), .address(address)
);

// ==== verif/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ns

module tb_mips_cpu_bus import isa_pkg::*, bus_pkg::*; ();

    localparam int    NUM_RANDOM     = 60;
    localparam int    PROG_LEN       = NUM_RANDOM + 2;
    localparam int    DATA_WORDS     = 64;
    localparam word_t DATA_BASE      = 32'h0000_1000;
    localparam int    TIMEOUT_CYCLES = NUM_RANDOM * 12 + 100;

    logic       clk;
    logic       reset = 1'b1;
    logic       waitrequest = 1'b1;
    word_t      readdata = '0;
    logic       active;
    logic       read;
    logic       write;
    logic [3:0] byteenable;
    word_t      address;
    word_t      writedata;
    word_t      register_v0;

    word_t prog [PROG_LEN];
    word_t mem_data [DATA_WORDS];
    word_t model_data [DATA_WORDS];
    word_t model_regs [REG_COUNT];
    word_t fetch_q [$];
    word_t load_q [$];
    word_t store_addr_q [$];
    word_t store_data_q [$];
    logic  busy;
    logic  halted = 1'b0;
    int    wait_left;
    int    cycles = 0;

    mips_cpu_bus dut_i (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input word_t expected, input word_t got);
        abort_run($sformatf("[ERROR] %0t ns: %s expected %h, got %h", $time, name, expected, got));
    endtask

    function automatic logic in_data(input word_t a);
        return a >= DATA_BASE && a < DATA_BASE + 32'(4 * DATA_WORDS);
    endfunction

    function automatic word_t fill_word(input int k);
        return (DATA_BASE + 32'(4 * k)) * 32'h9E37_79B1;
    endfunction

    function automatic word_t lookup(input word_t a);
        int k;
        if (in_data(a)) begin
            k = int'((a - DATA_BASE) >> 2);
            return mem_data[k];
        end
        k = int'((a - RESET_VECTOR) >> 2);
        return (k >= 0 && k < PROG_LEN) ? prog[k] : '0;
    endfunction

    task automatic build_program();
        funct_t   r_ops [10];
        opcode_t  i_ops [7];
        int       kind, pick, span, off;
        logic     prev_cti;
        reg_idx_t rs, rt, rd;
        r_ops = '{SLL, SRL, SRA, ADDU, SUBU, AND, OR, XOR, SLT, SLTU};
        i_ops = '{ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI};
        prev_cti = 1'b0;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            kind = $urandom_range(0, 9);
            pick = $urandom_range(0, 63);
            rs = reg_idx_t'($urandom_range(0, 7));
            rt = reg_idx_t'($urandom_range(0, 7));
            rd = reg_idx_t'($urandom_range(0, 7));
            // no branch in a delay slot and no target past the end
            if (kind >= 8 && (prev_cti || i > NUM_RANDOM - 2)) begin
                kind = 0;
            end
            span = (NUM_RANDOM - 1 - i > 3) ? 3 : NUM_RANDOM - 1 - i;
            off = (kind >= 8) ? int'($urandom_range(1, span)) : 0;
            case (kind)
                0, 1, 2: prog[i] = {SPECIAL, rs, rt, rd, 5'($urandom_range(0, 31)), r_ops[pick % 10]};
                3, 4, 5: prog[i] = {i_ops[pick % 7], rs, rt, 16'($urandom)};
                6:       prog[i] = {LW, 5'd0, rt, 16'(DATA_BASE + 32'(4 * pick))};
                7:       prog[i] = {SW, 5'd0, rt, 16'(DATA_BASE + 32'(4 * pick))};
                8:       prog[i] = {(pick % 2 == 0) ? BEQ : BNE, rs, rt, 16'(off)};
                default: prog[i] = {J, 26'((RESET_VECTOR + 32'(4 * (i + 1 + off))) >> 2)};
            endcase
            prev_cti = (kind >= 8);
        end
        // jr $0 ends the program with a nop in its delay slot
        prog[NUM_RANDOM] = {SPECIAL, 5'd0, 5'd0, 5'd0, 5'd0, JR};
        prog[NUM_RANDOM + 1] = '0;
    endtask

    task automatic run_model();
        word_t    ins, a, b, se, val, tgt, ptarget, pc;
        logic     taken, pending, wen;
        reg_idx_t dst;
        int       k;
        pc = RESET_VECTOR;
        pending = 1'b0;
        ptarget = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            model_regs[r] = '0;
        end
        while (pc != '0 && fetch_q.size() < 4 * PROG_LEN) begin
            fetch_q.push_back(pc);
            ins = prog[int'((pc - RESET_VECTOR) >> 2)];
            a = model_regs[ins[25:21]];
            b = model_regs[ins[20:16]];
            se = {{16{ins[15]}}, ins[15:0]};
            tgt = pc + 32'd4 + (se << 2);
            taken = 1'b0;
            wen = 1'b1;
            dst = ins[20:16];
            val = '0;
            case (ins[31:26])
                SPECIAL: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        SLL:  val = b << ins[10:6];
                        SRL:  val = b >> ins[10:6];
                        SRA:  val = $signed(b) >>> ins[10:6];
                        ADDU: val = a + b;
                        SUBU: val = a - b;
                        AND:  val = a & b;
                        OR:   val = a | b;
                        XOR:  val = a ^ b;
                        SLT:  val = {31'b0, $signed(a) < $signed(b)};
                        SLTU: val = {31'b0, a < b};
                        JR: begin
                            wen = 1'b0;
                            taken = 1'b1;
                            tgt = a;
                        end
                        default: wen = 1'b0;
                    endcase
                end
                ADDIU: val = a + se;
                SLTI:  val = {31'b0, $signed(a) < $signed(se)};
                SLTIU: val = {31'b0, a < se};
                ANDI:  val = a & {16'b0, ins[15:0]};
                ORI:   val = a | {16'b0, ins[15:0]};
                XORI:  val = a ^ {16'b0, ins[15:0]};
                LUI:   val = {ins[15:0], 16'b0};
                LW: begin
                    load_q.push_back(a + se);
                    k = int'((a + se - DATA_BASE) >> 2);
                    val = model_data[k];
                end
                SW: begin
                    store_addr_q.push_back(a + se);
                    store_data_q.push_back(b);
                    k = int'((a + se - DATA_BASE) >> 2);
                    model_data[k] = b;
                    wen = 1'b0;
                end
                BEQ: {wen, taken} = {1'b0, a == b};
                BNE: {wen, taken} = {1'b0, a != b};
                J: begin
                    {wen, taken} = 2'b01;
                    tgt = {pc[31:28], ins[25:0], 2'b00};
                end
                default: wen = 1'b0;
            endcase
            if (wen && dst != '0) begin
                model_regs[dst] = val;
            end
            // a pending target wins over pc+4 after the delay slot
            pc = pending ? ptarget : pc + 32'd4;
            pending = taken;
            ptarget = tgt;
        end
    endtask

    task automatic complete_transfer();
        int k;
        if (write) begin
            assert (store_addr_q.size() > 0) else abort_run("write seen with no store left");
            assert (address == store_addr_q[0])
                else report_mismatch("address", store_addr_q[0], address);
            assert (writedata == store_data_q[0])
                else report_mismatch("writedata", store_data_q[0], writedata);
            assert (byteenable == 4'b1111)
                else report_mismatch("byteenable", 32'h0000_000F, 32'(byteenable));
            k = int'((address - DATA_BASE) >> 2);
            mem_data[k] = writedata;
            void'(store_addr_q.pop_front());
            void'(store_data_q.pop_front());
        end else if (in_data(address)) begin
            assert (load_q.size() > 0) else abort_run("data read seen with no load left");
            assert (address == load_q[0]) else report_mismatch("address", load_q[0], address);
            void'(load_q.pop_front());
        end else begin
            assert (fetch_q.size() > 0) else abort_run("fetch seen after the program ended");
            assert (address == fetch_q[0]) else report_mismatch("address", fetch_q[0], address);
            void'(fetch_q.pop_front());
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // waitrequest idles high and each transfer adds 0 to 3 waits
    always @(posedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            busy = 1'b0;
            for (int k = 0; k < DATA_WORDS; k++) begin
                mem_data[k] = fill_word(k);
            end
        end else begin
            if (!active) begin
                halted = 1'b1;
            end
            if (read || write) begin
                assert (!halted) else abort_run("bus strobe seen after the CPU halted");
                if (!busy) begin
                    busy = 1'b1;
                    wait_left = $urandom_range(0, 3);
                end
                if (!waitrequest) begin
                    complete_transfer();
                    busy = 1'b0;
                    waitrequest <= 1'b1;
                end else if (wait_left == 0) begin
                    waitrequest <= 1'b0;
                    readdata <= lookup(address);
                end else begin
                    wait_left--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        assert (cycles < TIMEOUT_CYCLES)
            else abort_run($sformatf("timeout: CPU did not halt within %0d cycles", cycles));
    end

    initial begin
        void'($urandom(9));
        build_program();
        for (int k = 0; k < DATA_WORDS; k++) begin
            model_data[k] = fill_word(k);
        end
        run_model();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (halted);
        repeat (10) @(posedge clk);
        assert (fetch_q.size() == 0 && load_q.size() == 0 && store_addr_q.size() == 0)
            else abort_run("CPU halted before the program was finished");
        assert (register_v0 == model_regs[REG_V0])
            else report_mismatch("register_v0", model_regs[REG_V0], register_v0);
        for (int k = 0; k < DATA_WORDS; k++) begin
            assert (mem_data[k] == model_data[k])
                else report_mismatch($sformatf("mem_data[%0d]", k), model_data[k], mem_data[k]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
